// ==== video_regs.f ====
common/vid_regs_pkg.sv
rtl/bus_sync.sv
reg_interface/reg_interface.sv
rtl/vram_mem.sv
rtl/xr_mem.sv
rtl/video_regs_top.sv
tests/tb_clock.sv
tests/video_regs_tb.sv

// ==== tests/video_regs_tb.sv ====
module video_regs_tb;
    import vid_regs_pkg::*;

    localparam int TIMER_TICK  = 10;
    localparam int TIMER_GAP   = 100;   // cycles between the two timer latch points
    localparam int BYTE_CYCLES = 8;     // cs_n low 4, then high 4

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_READ_BYTE, OP_WAIT, OP_IDLE, OP_TIMER
    } op_t;

    typedef struct packed {
        op_t        op;
        reg_num_t   reg_num;
        word_t      data;       // write data, idle cycles or byte select
        word_t      expected;
    } entry_t;

    logic           clk;
    logic           reset;
    logic           bus_cs_n;
    logic           bus_rd_nwr;
    reg_num_t       bus_reg_num;
    logic           bus_bytesel;
    byte_t          bus_wdata;
    byte_t          bus_rdata;

    entry_t         entry_q [$];
    string          name_q [$];
    logic           table_built = 1'b0;
    logic [31:0]    lcg_state;
    word_t          timer_prev;
    logic           timer_seen = 1'b0;

    // reference copy of the register block and both memories
    word_t          vram_shadow [4096];
    word_t          xr_shadow [256];
    word_t          m_rd_xaddr;
    word_t          m_wr_xaddr;
    word_t          m_xdata;        // last XR pre-read
    word_t          m_rd_incr;
    word_t          m_rd_addr;
    word_t          m_data;         // last VRAM pre-read
    word_t          m_wr_incr;
    word_t          m_wr_addr;
    logic [3:0]     m_wrmask;

    tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

    video_regs_top #(
        .TIMER_TICK     (TIMER_TICK)
    ) dut (
        .clk            (clk),
        .reset_i        (reset),
        .bus_cs_n_i     (bus_cs_n),
        .bus_rd_nwr_i   (bus_rd_nwr),
        .bus_reg_num_i  (bus_reg_num),
        .bus_bytesel_i  (bus_bytesel),
        .bus_data_i     (bus_wdata),
        .bus_data_o     (bus_rdata)
    );

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic word_t merge_nibbles(input word_t old_w, input word_t new_w,
                                            input logic [3:0] mask);
        word_t bits;
        bits = {{4{mask[3]}}, {4{mask[2]}}, {4{mask[1]}}, {4{mask[0]}}};
        return (new_w & bits) | (old_w & ~bits);
    endfunction

    function automatic word_t model_value(input reg_num_t r);
        case (r)
            XM_SYS_CTRL: return {1'b0, 11'b0, m_wrmask};   // idle after every wait
            XM_RD_XADDR: return m_rd_xaddr;
            XM_WR_XADDR: return m_wr_xaddr;
            XM_XDATA:    return m_xdata;
            XM_RD_INCR:  return m_rd_incr;
            XM_RD_ADDR:  return m_rd_addr;
            XM_WR_INCR:  return m_wr_incr;
            XM_WR_ADDR:  return m_wr_addr;
            default:     return m_data;
        endcase
    endfunction

    task automatic push_entry(input op_t op, input reg_num_t r, input word_t d,
                              input word_t exp, input string name);
        entry_q.push_back('{op: op, reg_num: r, data: d, expected: exp});
        name_q.push_back(name);
    endtask

    task automatic queue_write(input string name, input reg_num_t r, input word_t d);
        logic mem_op;
        mem_op = 1'b0;
        push_entry(OP_WRITE, r, d, 16'h0000, name);
        case (r)
            XM_SYS_CTRL: m_wrmask = d[3:0];
            XM_RD_XADDR: begin
                m_xdata    = xr_shadow[d[7:0]];     // pre-read at the new address
                m_rd_xaddr = d + 16'd1;
                mem_op     = 1'b1;
            end
            XM_WR_XADDR: m_wr_xaddr = d;
            XM_XDATA: begin
                xr_shadow[m_wr_xaddr[7:0]] = d;
                m_wr_xaddr = m_wr_xaddr + 16'd1;
                mem_op     = 1'b1;
            end
            XM_RD_INCR:  m_rd_incr = d;
            XM_RD_ADDR: begin
                m_data    = vram_shadow[d[11:0]];
                m_rd_addr = d + m_rd_incr;
                mem_op    = 1'b1;
            end
            XM_WR_INCR:  m_wr_incr = d;
            XM_WR_ADDR:  m_wr_addr = d;
            XM_DATA, XM_DATA_2: begin
                vram_shadow[m_wr_addr[11:0]] =
                    merge_nibbles(vram_shadow[m_wr_addr[11:0]], d, m_wrmask);
                m_wr_addr = m_wr_addr + m_wr_incr;
                mem_op    = 1'b1;
            end
            default: begin
            end
        endcase
        if (mem_op) begin
            push_entry(OP_WAIT, XM_SYS_CTRL, 16'h0000, 16'h0000, name);
        end
    endtask

    task automatic queue_read(input string name, input reg_num_t r);
        push_entry(OP_READ, r, 16'h0000, model_value(r), name);
        if (r == XM_XDATA) begin
            m_xdata    = xr_shadow[m_rd_xaddr[7:0]];    // odd read starts next pre-read
            m_rd_xaddr = m_rd_xaddr + 16'd1;
            push_entry(OP_WAIT, XM_SYS_CTRL, 16'h0000, 16'h0000, name);
        end else if (r == XM_DATA || r == XM_DATA_2) begin
            m_data    = vram_shadow[m_rd_addr[11:0]];
            m_rd_addr = m_rd_addr + m_rd_incr;
            push_entry(OP_WAIT, XM_SYS_CTRL, 16'h0000, 16'h0000, name);
        end
    endtask

    task automatic queue_byte_read(input string name, input reg_num_t r, input logic odd);
        word_t w;
        w = model_value(r);
        push_entry(OP_READ_BYTE, r, {15'b0, odd}, odd ? {8'h00, w[7:0]} : {8'h00, w[15:8]},
                   name);
    endtask

    task automatic build_table();
        word_t      start;
        word_t      xstart;
        reg_num_t   addr_regs [6];
        addr_regs = '{XM_RD_XADDR, XM_WR_XADDR, XM_RD_INCR, XM_RD_ADDR, XM_WR_INCR, XM_WR_ADDR};
        foreach (vram_shadow[i]) begin
            vram_shadow[i] = 16'h0000;      // VRAM clears on reset
        end
        foreach (xr_shadow[i]) begin
            xr_shadow[i] = 16'h0000;
        end
        {m_rd_xaddr, m_wr_xaddr, m_rd_incr, m_rd_addr, m_wr_incr, m_wr_addr} = '0;
        m_xdata  = 16'h0000;
        m_data   = 16'h0000;
        m_wrmask = 4'hF;

        // timer goes first while its count is small
        push_entry(OP_TIMER, XM_TIMER, 16'h0000, 16'h0000, "timer first read");
        push_entry(OP_IDLE, XM_SYS_CTRL, TIMER_GAP - 2 * BYTE_CYCLES, 16'h0000, "timer gap");
        push_entry(OP_TIMER, XM_TIMER, 16'h0000, 16'h0000, "timer second read");

        queue_read("reset sys_ctrl", XM_SYS_CTRL);
        foreach (addr_regs[i]) begin
            queue_read($sformatf("reset reg %0d", addr_regs[i]), addr_regs[i]);
        end
        foreach (addr_regs[i]) begin
            queue_write($sformatf("readback write reg %0d", addr_regs[i]), addr_regs[i],
                        next_random());
            queue_read($sformatf("readback reg %0d", addr_regs[i]), addr_regs[i]);
        end
        queue_byte_read("odd byte of wr_incr", XM_WR_INCR, 1'b1);

        start = next_random() & 16'h0fff;
        queue_write("vram wr_incr", XM_WR_INCR, 16'd3);
        queue_write("vram wr_addr", XM_WR_ADDR, start);
        repeat (6) queue_write("vram data write", XM_DATA, next_random());
        queue_write("vram rd_incr", XM_RD_INCR, 16'd3);
        queue_write("vram rd_addr", XM_RD_ADDR, start);
        repeat (6) queue_read("vram data read", XM_DATA);
        queue_read("vram rd_addr after reads", XM_RD_ADDR);

        queue_write("mask set", XM_SYS_CTRL, 16'h0005);
        queue_read("mask readback", XM_SYS_CTRL);
        queue_write("mask wr_addr", XM_WR_ADDR, start);
        queue_write("mask data write", XM_DATA, next_random());
        queue_write("mask rd_addr", XM_RD_ADDR, start);
        queue_read("mask merged word", XM_DATA);

        xstart = next_random() & 16'h00f0;
        queue_write("xr wr_xaddr", XM_WR_XADDR, xstart);
        repeat (4) queue_write("xr data write", XM_XDATA, next_random());
        queue_read("xr wr_xaddr after writes", XM_WR_XADDR);
        queue_write("xr rd_xaddr", XM_RD_XADDR, xstart);
        repeat (4) queue_read("xr data read", XM_XDATA);
        queue_read("xr rd_xaddr after reads", XM_RD_XADDR);
    endtask

    task automatic report_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    // one host byte cycle, entered and left on a falling edge
    task automatic bus_access(input logic rd, input reg_num_t r, input logic odd,
                              input byte_t wdata, output byte_t rdata);
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = rd;
        bus_reg_num = r;
        bus_bytesel = odd;
        bus_wdata   = wdata;
        repeat (4) @(negedge clk);
        rdata    = bus_rdata;           // settled one cycle after the strobe
        bus_cs_n = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic write_word(input reg_num_t r, input word_t d);
        byte_t unused;
        bus_access(1'b0, r, 1'b0, d[15:8], unused);
        bus_access(1'b0, r, 1'b1, d[7:0], unused);
    endtask

    task automatic read_word(input reg_num_t r, output word_t d);
        bus_access(1'b1, r, 1'b0, 8'h00, d[15:8]);
        bus_access(1'b1, r, 1'b1, 8'h00, d[7:0]);
    endtask

    task automatic wait_idle();
        byte_t status;
        status = 8'h80;
        while (status[7]) begin         // busy flag is bit 15
            bus_access(1'b1, XM_SYS_CTRL, 1'b0, 8'h00, status);
        end
    endtask

    task automatic check_timer(input string name);
        word_t now;
        word_t max_step;
        max_step = TIMER_GAP / TIMER_TICK + 1;
        read_word(XM_TIMER, now);
        if (timer_seen && (now <= timer_prev || now - timer_prev > max_step)) begin
            $display("FAILED %s: expected %h to %h, actual %h", name, timer_prev + 16'd1,
                     timer_prev + max_step, now);
            report_failure();
        end
        timer_prev = now;
        timer_seen = 1'b1;
    endtask

    task automatic run_entry(input entry_t e, input string name);
        word_t w;
        byte_t b;
        case (e.op)
            OP_WRITE: write_word(e.reg_num, e.data);
            OP_READ: begin
                read_word(e.reg_num, w);
                check_word(name, e.expected, w);
            end
            OP_READ_BYTE: begin
                bus_access(1'b1, e.reg_num, e.data[0], 8'h00, b);
                check_byte(name, e.expected[7:0], b);
            end
            OP_WAIT: wait_idle();
            OP_IDLE: repeat (e.data) @(negedge clk);
            OP_TIMER: check_timer(name);
            default: begin
            end
        endcase
    endtask

    initial begin
        wait (table_built);
        repeat (200 * entry_q.size() + 500) @(posedge clk);
        $display("watchdog expired before the stimulus table was done, the run timed out");
        report_failure();
    end

    initial begin
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = XM_SYS_CTRL;
        bus_bytesel = 1'b0;
        bus_wdata   = 8'h00;
        reset       = 1'b1;
        lcg_state   = 32'h7f59_671a;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (entry_q[i]) begin
            run_entry(entry_q[i], name_q[i]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 8            // time units per clock cycle
)(
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== rtl/video_regs_top.sv ====
module video_regs_top #(
    parameter int TIMER_TICK = 10                   // clocks per timer count
)(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,
    input  wire logic                   bus_rd_nwr_i,
    input  wire vid_regs_pkg::reg_num_t bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire vid_regs_pkg::byte_t    bus_data_i,
    output      vid_regs_pkg::byte_t    bus_data_o
);
    import vid_regs_pkg::*;

    bus_evt_t   evt;
    mem_req_t   vram_req;
    mem_req_t   xr_req;
    logic       vram_ack;
    logic       xr_ack;
    word_t      vram_data;
    word_t      xr_data;

    bus_sync u_bus_sync (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .evt_o          (evt)
    );

    reg_interface #(
        .TIMER_TICK     (TIMER_TICK)
    ) u_reg_interface (
        .clk            (clk),
        .reset_i        (reset_i),
        .evt_i          (evt),
        .bus_data_o     (bus_data_o),
        .vram_req_o     (vram_req),
        .xr_req_o       (xr_req),
        .vram_ack_i     (vram_ack),
        .xr_ack_i       (xr_ack),
        .vram_data_i    (vram_data),
        .xr_data_i      (xr_data)
    );

    vram_mem u_vram_mem (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_i          (vram_req),
        .ack_o          (vram_ack),
        .data_o         (vram_data)
    );

    xr_mem u_xr_mem (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_i          (xr_req),
        .ack_o          (xr_ack),
        .data_o         (xr_data)
    );

endmodule

// ==== rtl/xr_mem.sv ====
module xr_mem (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire vid_regs_pkg::mem_req_t req_i,      // wrmask not used here
    output      logic                   ack_o,
    output      vid_regs_pkg::word_t    data_o
);
    import vid_regs_pkg::*;

    localparam int DEPTH = 256;

    word_t          mem [DEPTH];
    logic [7:0]     word_addr;
    logic           start;

    assign word_addr = req_i.addr[7:0];
    assign start     = req_i.sel && !ack_o;     // new request this cycle

    always_ff @(posedge clk) begin
        if (start) begin
            data_o <= mem[word_addr];
            if (req_i.wr) begin
                mem[word_addr] <= req_i.data;   // full word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= start;
        end
    end

endmodule

// ==== rtl/vram_mem.sv ====
module vram_mem (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire vid_regs_pkg::mem_req_t req_i,
    output      logic                   ack_o,      // one cycle, read data valid
    output      vid_regs_pkg::word_t    data_o
);
    import vid_regs_pkg::*;

    localparam int DEPTH = 4096;

    word_t          mem [DEPTH];
    logic           stage1;         // first half of the ack delay
    logic [11:0]    word_addr;

    assign word_addr = req_i.addr[11:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage1 <= 1'b0;
            ack_o  <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // restart only after the previous ack has gone
            stage1 <= req_i.sel && !stage1 && !ack_o;
            ack_o  <= stage1;
            if (stage1) begin
                data_o <= mem[word_addr];
                if (req_i.wr) begin
                    for (int n = 0; n < 4; n++) begin
                        if (req_i.wrmask[n]) begin
                            mem[word_addr][n*4 +: 4] <= req_i.data[n*4 +: 4];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== reg_interface/reg_interface.sv ====
module reg_interface #(
    parameter int TIMER_TICK = 10                       // clocks per timer count
)(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire vid_regs_pkg::bus_evt_t evt_i,          // byte access from bus_sync
    output      vid_regs_pkg::byte_t    bus_data_o,     // read byte toward host
    output      vid_regs_pkg::mem_req_t vram_req_o,
    output      vid_regs_pkg::mem_req_t xr_req_o,
    input  wire logic                   vram_ack_i,
    input  wire logic                   xr_ack_i,
    input  wire vid_regs_pkg::word_t    vram_data_i,
    input  wire vid_regs_pkg::word_t    xr_data_i
);
    import vid_regs_pkg::*;

    localparam int TICK_W = $clog2(TIMER_TICK + 1);

    addr_t              reg_rd_xaddr;
    addr_t              reg_wr_xaddr;
    word_t              reg_xdata;          // last XR pre-read result
    word_t              reg_rd_incr;
    addr_t              reg_rd_addr;
    word_t              reg_data;           // last VRAM pre-read result
    word_t              reg_wr_incr;
    addr_t              reg_wr_addr;
    logic [3:0]         reg_wrmask;
    byte_t              reg_data_even;      // held until the odd byte arrives
    byte_t              reg_xdata_even;
    word_t              reg_timer;
    logic [TICK_W-1:0]  tick_cnt;
    byte_t              timer_latch;        // low timer byte, frozen on even reads
    reg_num_t           rd_reg_num;         // last accessed register
    logic               rd_bytesel;
    logic               busy;
    word_t              rd_word;

    // replace one byte of a 16-bit register
    function automatic word_t set_byte(input word_t w, input logic odd, input byte_t b);
        return odd ? {w[15:8], b} : {b, w[7:0]};
    endfunction

    // each sel doubles as its memory's single pending credit
    assign busy = vram_req_o.sel || xr_req_o.sel;

    always_comb begin
        case (rd_reg_num)
            XM_SYS_CTRL: rd_word = {busy, 11'b0, reg_wrmask};
            XM_TIMER:    rd_word = {reg_timer[15:8], timer_latch};
            XM_RD_XADDR: rd_word = reg_rd_xaddr;
            XM_WR_XADDR: rd_word = reg_wr_xaddr;
            XM_XDATA:    rd_word = reg_xdata;
            XM_RD_INCR:  rd_word = reg_rd_incr;
            XM_RD_ADDR:  rd_word = reg_rd_addr;
            XM_WR_INCR:  rd_word = reg_wr_incr;
            XM_WR_ADDR:  rd_word = reg_wr_addr;
            default:     rd_word = reg_data;    // DATA, DATA_2 and unused numbers
        endcase
    end

    assign bus_data_o = rd_bytesel ? rd_word[7:0] : rd_word[15:8];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tick_cnt  <= '0;
            reg_timer <= '0;
        end else if (tick_cnt == TICK_W'(TIMER_TICK - 1)) begin
            tick_cnt  <= '0;
            reg_timer <= reg_timer + 16'd1;
        end else begin
            tick_cnt  <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_req_o.sel    <= 1'b0;
            vram_req_o.wr     <= 1'b0;
            vram_req_o.wrmask <= 4'hF;
            xr_req_o.sel      <= 1'b0;
            xr_req_o.wr       <= 1'b0;
            xr_req_o.wrmask   <= 4'hF;
            reg_rd_xaddr      <= '0;
            reg_wr_xaddr      <= '0;
            reg_rd_incr       <= '0;
            reg_rd_addr       <= '0;
            reg_wr_incr       <= '0;
            reg_wr_addr       <= '0;
            reg_wrmask        <= 4'hF;
            timer_latch       <= '0;
            rd_reg_num        <= XM_SYS_CTRL;
            rd_bytesel        <= 1'b0;
        end else begin
            if (vram_ack_i) begin
                if (vram_req_o.wr) begin
                    reg_wr_addr <= reg_wr_addr + reg_wr_incr;
                end else begin
                    reg_data    <= vram_data_i;     // pre-read result
                    reg_rd_addr <= reg_rd_addr + reg_rd_incr;
                end
                vram_req_o.sel <= 1'b0;
                vram_req_o.wr  <= 1'b0;
            end

            if (xr_ack_i) begin
                if (xr_req_o.wr) begin
                    reg_wr_xaddr <= reg_wr_xaddr + 16'd1;
                end else begin
                    reg_xdata    <= xr_data_i;
                    reg_rd_xaddr <= reg_rd_xaddr + 16'd1;
                end
                xr_req_o.sel <= 1'b0;
                xr_req_o.wr  <= 1'b0;
            end

            if (evt_i.write_strobe || evt_i.read_strobe) begin
                rd_reg_num <= evt_i.reg_num;        // selects the read mux
                rd_bytesel <= evt_i.bytesel;
            end

            if (evt_i.write_strobe) begin
                case (evt_i.reg_num)
                    XM_SYS_CTRL: begin
                        if (evt_i.bytesel) begin
                            reg_wrmask <= evt_i.data[3:0];
                        end
                    end
                    XM_RD_XADDR: begin
                        reg_rd_xaddr <= set_byte(reg_rd_xaddr, evt_i.bytesel, evt_i.data);
                        if (evt_i.bytesel) begin        // start XR pre-read
                            xr_req_o.sel  <= 1'b1;
                            xr_req_o.wr   <= 1'b0;
                            xr_req_o.addr <= {reg_rd_xaddr[15:8], evt_i.data};
                        end
                    end
                    XM_WR_XADDR: begin
                        reg_wr_xaddr <= set_byte(reg_wr_xaddr, evt_i.bytesel, evt_i.data);
                    end
                    XM_XDATA: begin
                        if (!evt_i.bytesel) begin
                            reg_xdata_even <= evt_i.data;
                        end else begin
                            xr_req_o.sel  <= 1'b1;
                            xr_req_o.wr   <= 1'b1;
                            xr_req_o.addr <= reg_wr_xaddr;
                            xr_req_o.data <= {reg_xdata_even, evt_i.data};
                        end
                    end
                    XM_RD_INCR: begin
                        reg_rd_incr <= set_byte(reg_rd_incr, evt_i.bytesel, evt_i.data);
                    end
                    XM_RD_ADDR: begin
                        reg_rd_addr <= set_byte(reg_rd_addr, evt_i.bytesel, evt_i.data);
                        if (evt_i.bytesel) begin        // start VRAM pre-read
                            vram_req_o.sel  <= 1'b1;
                            vram_req_o.wr   <= 1'b0;
                            vram_req_o.addr <= {reg_rd_addr[15:8], evt_i.data};
                        end
                    end
                    XM_WR_INCR: begin
                        reg_wr_incr <= set_byte(reg_wr_incr, evt_i.bytesel, evt_i.data);
                    end
                    XM_WR_ADDR: begin
                        reg_wr_addr <= set_byte(reg_wr_addr, evt_i.bytesel, evt_i.data);
                    end
                    XM_DATA, XM_DATA_2: begin
                        if (!evt_i.bytesel) begin
                            reg_data_even <= evt_i.data;
                        end else begin
                            vram_req_o.sel    <= 1'b1;
                            vram_req_o.wr     <= 1'b1;
                            vram_req_o.wrmask <= reg_wrmask;
                            vram_req_o.addr   <= reg_wr_addr;
                            vram_req_o.data   <= {reg_data_even, evt_i.data};
                        end
                    end
                    default: begin
                    end
                endcase
            end

            if (evt_i.read_strobe) begin
                if (!evt_i.bytesel) begin
                    timer_latch <= reg_timer[7:0];  // any even read freezes low byte
                end else if (evt_i.reg_num == XM_XDATA) begin
                    xr_req_o.sel  <= 1'b1;          // next XR pre-read
                    xr_req_o.wr   <= 1'b0;
                    xr_req_o.addr <= reg_rd_xaddr;
                end else if (evt_i.reg_num == XM_DATA || evt_i.reg_num == XM_DATA_2) begin
                    vram_req_o.sel  <= 1'b1;        // next VRAM pre-read
                    vram_req_o.wr   <= 1'b0;
                    vram_req_o.addr <= reg_rd_addr;
                end
            end
        end
    end

endmodule

// ==== rtl/bus_sync.sv ====
module bus_sync (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,     // chip select, active low
    input  wire logic                   bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire vid_regs_pkg::reg_num_t bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 1 = odd (low) byte
    input  wire vid_regs_pkg::byte_t    bus_data_i,
    output      vid_regs_pkg::bus_evt_t evt_o
);
    import vid_regs_pkg::*;

    logic [1:0] cs_n_sync;          // bit 1 is the synchronized copy
    logic       cs_n_last;          // previous synchronized cs_n
    logic [1:0] rd_nwr_sync;
    logic [1:0] bytesel_sync;
    reg_num_t   reg_num_s1;
    reg_num_t   reg_num_s2;
    byte_t      data_s1;
    byte_t      data_s2;
    logic       cs_fall;

    assign cs_fall = !cs_n_sync[1] && cs_n_last;   // start of a host byte cycle

    // two flops on every bus input
    always_ff @(posedge clk) begin
        rd_nwr_sync  <= {rd_nwr_sync[0], bus_rd_nwr_i};
        bytesel_sync <= {bytesel_sync[0], bus_bytesel_i};
        reg_num_s1   <= bus_reg_num_i;
        reg_num_s2   <= reg_num_s1;
        data_s1      <= bus_data_i;
        data_s2      <= data_s1;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_sync          <= 2'b11;    // bus idle
            cs_n_last          <= 1'b1;
            evt_o.write_strobe <= 1'b0;
            evt_o.read_strobe  <= 1'b0;
        end else begin
            cs_n_sync          <= {cs_n_sync[0], bus_cs_n_i};
            cs_n_last          <= cs_n_sync[1];
            evt_o.write_strobe <= cs_fall && !rd_nwr_sync[1];
            evt_o.read_strobe  <= cs_fall && rd_nwr_sync[1];
            if (cs_fall) begin
                evt_o.reg_num <= reg_num_s2;
                evt_o.bytesel <= bytesel_sync[1];
                evt_o.data    <= data_s2;
            end
        end
    end

endmodule

// ==== common/vid_regs_pkg.sv ====
package vid_regs_pkg;

    typedef logic [15:0] word_t;        // register or memory word
    typedef logic [7:0]  byte_t;        // host bus byte
    typedef logic [15:0] addr_t;        // memories decode the low bits only
    typedef logic [3:0]  reg_num_t;

    // host visible register numbers
    localparam reg_num_t XM_SYS_CTRL = 4'h0;    // busy flag and write mask
    localparam reg_num_t XM_TIMER    = 4'h1;    // free-running tick timer
    localparam reg_num_t XM_RD_XADDR = 4'h2;    // XR read address
    localparam reg_num_t XM_WR_XADDR = 4'h3;    // XR write address
    localparam reg_num_t XM_XDATA    = 4'h4;    // XR data port
    localparam reg_num_t XM_RD_INCR  = 4'h5;    // VRAM read increment
    localparam reg_num_t XM_RD_ADDR  = 4'h6;    // VRAM read address
    localparam reg_num_t XM_WR_INCR  = 4'h7;    // VRAM write increment
    localparam reg_num_t XM_WR_ADDR  = 4'h8;    // VRAM write address
    localparam reg_num_t XM_DATA     = 4'h9;    // VRAM data port
    localparam reg_num_t XM_DATA_2   = 4'hA;    // second VRAM data port

    // request from the register block toward one memory
    typedef struct packed {
        logic       sel;        // held until ack
        logic       wr;         // 1 = write, 0 = read
        logic [3:0] wrmask;     // nibble enables
        addr_t      addr;
        word_t      data;       // write data
    } mem_req_t;

    // one host byte access after synchronization
    typedef struct packed {
        logic       write_strobe;   // single cycle
        logic       read_strobe;    // single cycle
        reg_num_t   reg_num;
        logic       bytesel;        // 0 = even (high) byte
        byte_t      data;
    } bus_evt_t;

endpackage
